/* fib_hash.sv */
`timescale 1ns/1ps
`include "fib_settings.svh"

module fib_hash (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [`FIB_PREFIX_W-1:0] key,
    output logic [`FIB_HASH_W-1:0]   hash
);

    // Number of full index-wide slices in the key
    localparam int SLICES = `FIB_PREFIX_W / `FIB_HASH_W;

    logic [`FIB_HASH_W-1:0] fold;

    // Fold the key into index-wide slices and XOR them together
    always_comb begin
        fold = '0;
        for (int i = 0; i < SLICES; i++) begin
            fold = fold ^ key[i*`FIB_HASH_W +: `FIB_HASH_W];
        end
        // Leftover top bits, zero-extended
        fold = fold ^ `FIB_HASH_W'(key[`FIB_PREFIX_W-1:SLICES*`FIB_HASH_W]);
    end

    // One cycle of latency from key to hash
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hash <= '0;
        end else begin
            hash <= fold;
        end
    end

endmodule

/* fib_lpm_engine.sv */
`timescale 1ns/1ps
`include "fib_settings.svh"

module fib_lpm_engine
    import fib_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     lookup_start,
    input  logic [`FIB_PREFIX_W-1:0] pit_in_prefix,
    input  logic [`FIB_BYTE_W-1:0]   pit_in_metadata,
    input  logic [`FIB_HASH_W-1:0]   lookup_hash,
    input  logic                     rd_valid,
    output logic [`FIB_PREFIX_W-1:0] hash_key,
    output logic [`FIB_LEN_W-1:0]    rd_len,
    output logic [`FIB_HASH_W-1:0]   rd_hash,
    output logic                     spi_tx_valid,
    output logic [`FIB_BYTE_W-1:0]   data_fib_to_spi
);

    localparam int CNT_W = $clog2(`FIB_PREFIX_BYTES);
    localparam logic [CNT_W-1:0] PREFIX_LAST = CNT_W'(`FIB_PREFIX_BYTES - 1);

    lpm_state_t               state;
    logic [`FIB_LEN_W-1:0]    len;
    logic [CNT_W-1:0]         byte_cnt;
    logic [`FIB_BYTE_W-1:0]   meta_reg;
    logic [`FIB_PREFIX_W-1:0] total_sr;
    logic [`FIB_PREFIX_W-1:0] work_prefix;
    logic                     found;

    // Stop on a hit or once the shortest length has been tried
    assign found = rd_valid || (len == '0);

    // Control path and SPI output
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state           <= lpm_idle;
            len             <= '0;
            byte_cnt        <= '0;
            spi_tx_valid    <= 1'b0;
            data_fib_to_spi <= '0;
        end else begin
            spi_tx_valid <= 1'b0;
            case (state)
                lpm_idle: begin
                    if (lookup_start) begin
                        len   <= pit_in_metadata[`FIB_LEN_W-1:0];
                        state <= lpm_hash;
                    end
                end
                lpm_hash: begin
                    state <= lpm_check;
                end
                lpm_check: begin
                    if (found) begin
                        state <= lpm_send_meta;
                    end else begin
                        // Try one bit shorter
                        len   <= len - 1'b1;
                        state <= lpm_hash;
                    end
                end
                lpm_send_meta: begin
                    spi_tx_valid    <= 1'b1;
                    data_fib_to_spi <= meta_reg;
                    byte_cnt        <= '0;
                    state           <= lpm_send_total;
                end
                lpm_send_total: begin
                    spi_tx_valid    <= 1'b1;
                    data_fib_to_spi <= total_sr[`FIB_PREFIX_W-1 -: `FIB_BYTE_W];
                    byte_cnt        <= byte_cnt + 1'b1;
                    if (byte_cnt == PREFIX_LAST) begin
                        state <= lpm_send_match;
                    end
                end
                lpm_send_match: begin
                    spi_tx_valid    <= 1'b1;
                    data_fib_to_spi <= work_prefix[`FIB_PREFIX_W-1 -: `FIB_BYTE_W];
                    byte_cnt        <= byte_cnt + 1'b1;
                    if (byte_cnt == PREFIX_LAST) begin
                        state <= lpm_idle;
                    end
                end
                default: begin
                    state <= lpm_idle;
                end
            endcase
        end
    end

    // Sampled request and working prefix
    always_ff @(posedge clk) begin
        case (state)
            lpm_idle: begin
                if (lookup_start) begin
                    meta_reg    <= pit_in_metadata;
                    total_sr    <= pit_in_prefix;
                    work_prefix <= pit_in_prefix;
                end
            end
            lpm_check: begin
                // Bit zero is never cleared
                if (!found) begin
                    work_prefix[len] <= 1'b0;
                end
            end
            lpm_send_total: begin
                total_sr <= total_sr << `FIB_BYTE_W;
            end
            lpm_send_match: begin
                work_prefix <= work_prefix << `FIB_BYTE_W;
            end
            default: begin
                work_prefix <= work_prefix;
            end
        endcase
    end

    // Working prefix feeds the hash unit, its result comes back in the check state
    assign hash_key = work_prefix;
    assign rd_len   = len;
    assign rd_hash  = lookup_hash;

endmodule

/* fib_pkg.sv */
`include "fib_settings.svh"

package fib_pkg;

    // Incoming packet parser states
    typedef enum logic [2:0] {
        rx_idle,
        rx_meta,
        rx_prefix,
        rx_data,
        rx_wait_pit,
        rx_to_pit,
        rx_hash,
        rx_learn
    } rx_state_t;

    // Outgoing interest lookup states
    typedef enum logic [2:0] {
        lpm_idle,
        lpm_hash,
        lpm_check,
        lpm_send_meta,
        lpm_send_total,
        lpm_send_match
    } lpm_state_t;

endpackage

/* fib_rx_parser.sv */
`timescale 1ns/1ps
`include "fib_settings.svh"

module fib_rx_parser
    import fib_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     rx_valid,
    input  logic [`FIB_BYTE_W-1:0]   data_spi_to_fib,
    input  logic                     rejected,
    input  logic                     start_send_to_pit,
    input  logic [`FIB_HASH_W-1:0]   learn_hash,
    output logic                     prefix_ready,
    output logic [`FIB_PREFIX_W-1:0] pit_out_prefix,
    output logic [`FIB_BYTE_W-1:0]   pit_out_metadata,
    output logic [`FIB_BYTE_W-1:0]   data_fib_to_pit,
    output logic [`FIB_PREFIX_W-1:0] hash_key,
    output logic                     learn_we,
    output logic [`FIB_LEN_W-1:0]    learn_len
);

    // Counter wide enough for the payload, reused for the prefix
    localparam int CNT_W = $clog2(`FIB_DATA_BYTES);
    localparam int PAYLOAD_W = `FIB_DATA_BYTES * `FIB_BYTE_W;
    localparam logic [CNT_W-1:0] PREFIX_LAST = CNT_W'(`FIB_PREFIX_BYTES - 1);
    localparam logic [CNT_W-1:0] DATA_LAST = CNT_W'(`FIB_DATA_BYTES - 1);

    rx_state_t               state;
    logic [CNT_W-1:0]        byte_cnt;
    logic [`FIB_BYTE_W-1:0]  meta_reg;
    logic [`FIB_PREFIX_W-1:0] prefix_sr;
    logic [PAYLOAD_W-1:0]    payload_sr;
    logic [`FIB_PREFIX_W-1:0] prefix_next;

    // Prefix arrives MSB first, shift each byte in at the bottom
    assign prefix_next = {prefix_sr[`FIB_PREFIX_W-`FIB_BYTE_W-1:0], data_spi_to_fib};

    // Control path and registered outputs
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state            <= rx_idle;
            byte_cnt         <= '0;
            prefix_ready     <= 1'b0;
            pit_out_prefix   <= '0;
            pit_out_metadata <= '0;
            data_fib_to_pit  <= '0;
        end else begin
            // PIT strobe lasts a single cycle
            prefix_ready <= 1'b0;
            case (state)
                rx_idle: begin
                    if (rx_valid) begin
                        state <= rx_meta;
                    end
                end
                rx_meta: begin
                    byte_cnt <= '0;
                    state    <= rx_prefix;
                end
                rx_prefix: begin
                    byte_cnt <= byte_cnt + 1'b1;
                    if (byte_cnt == PREFIX_LAST) begin
                        byte_cnt <= '0;
                        if (meta_reg[`FIB_INTEREST_BIT]) begin
                            // Interest is complete, hand it to the PIT and learn it
                            prefix_ready     <= 1'b1;
                            pit_out_prefix   <= prefix_next;
                            pit_out_metadata <= meta_reg;
                            state            <= rx_hash;
                        end else begin
                            state <= rx_data;
                        end
                    end
                end
                rx_data: begin
                    byte_cnt <= byte_cnt + 1'b1;
                    if (byte_cnt == DATA_LAST) begin
                        // Whole data packet held, ask the PIT whether it wants it
                        prefix_ready     <= 1'b1;
                        pit_out_prefix   <= prefix_sr;
                        pit_out_metadata <= meta_reg;
                        state            <= rx_wait_pit;
                    end
                end
                rx_wait_pit: begin
                    // Rejection has priority over an accept in the same cycle
                    if (rejected) begin
                        state <= rx_hash;
                    end else if (start_send_to_pit) begin
                        byte_cnt <= '0;
                        state    <= rx_to_pit;
                    end
                end
                rx_to_pit: begin
                    // One payload byte per cycle, MSB first
                    data_fib_to_pit <= payload_sr[PAYLOAD_W-1 -: `FIB_BYTE_W];
                    byte_cnt        <= byte_cnt + 1'b1;
                    if (byte_cnt == DATA_LAST) begin
                        state <= rx_hash;
                    end
                end
                rx_hash: begin
                    // Hash unit registers the prefix this cycle
                    state <= rx_learn;
                end
                rx_learn: begin
                    state <= rx_idle;
                end
                default: begin
                    state <= rx_idle;
                end
            endcase
        end
    end

    // Packet contents
    always_ff @(posedge clk) begin
        case (state)
            rx_meta: begin
                meta_reg <= data_spi_to_fib;
            end
            rx_prefix: begin
                prefix_sr <= prefix_next;
            end
            rx_data: begin
                payload_sr <= {payload_sr[PAYLOAD_W-`FIB_BYTE_W-1:0], data_spi_to_fib};
            end
            rx_to_pit: begin
                payload_sr <= payload_sr << `FIB_BYTE_W;
            end
            default: begin
                payload_sr <= payload_sr;
            end
        endcase
    end

    // Prefix stays put from its last byte until the learning write
    assign hash_key = prefix_sr;

    // Learning write in the cycle after the hash is taken
    assign learn_we  = (state == rx_learn);
    assign learn_len = meta_reg[`FIB_LEN_W-1:0];

endmodule

/* fib_settings.svh */
`ifndef FIB_SETTINGS_SVH
`define FIB_SETTINGS_SVH

// Name prefix width in bits
`define FIB_PREFIX_W 64

// One link byte
`define FIB_BYTE_W 8

// Bytes carried per prefix and per data payload
`define FIB_PREFIX_BYTES 8
`define FIB_DATA_BYTES 32

// Table index width, also the hash output width
`define FIB_HASH_W 10

// Prefix length field in the metadata byte, one table row per length
`define FIB_LEN_W 6
`define FIB_LENGTHS 64

// Metadata bit that marks an interest packet
`define FIB_INTEREST_BIT 6

`endif

/* fib_table.sv */
`timescale 1ns/1ps
`include "fib_settings.svh"

module fib_table
    import fib_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     rx_valid,
    input  logic [`FIB_BYTE_W-1:0]   data_spi_to_fib,
    input  logic                     rejected,
    input  logic                     start_send_to_pit,
    input  logic                     lookup_start,
    input  logic [`FIB_PREFIX_W-1:0] pit_in_prefix,
    input  logic [`FIB_BYTE_W-1:0]   pit_in_metadata,
    output logic                     prefix_ready,
    output logic [`FIB_PREFIX_W-1:0] pit_out_prefix,
    output logic [`FIB_BYTE_W-1:0]   pit_out_metadata,
    output logic [`FIB_BYTE_W-1:0]   data_fib_to_pit,
    output logic                     spi_tx_valid,
    output logic [`FIB_BYTE_W-1:0]   data_fib_to_spi
);

    // Learning side
    logic [`FIB_PREFIX_W-1:0] learn_key;
    logic [`FIB_HASH_W-1:0]   learn_hash;
    logic                     learn_we;
    logic [`FIB_LEN_W-1:0]    learn_len;

    // Lookup side
    logic [`FIB_PREFIX_W-1:0] lookup_key;
    logic [`FIB_HASH_W-1:0]   lookup_hash;
    logic [`FIB_LEN_W-1:0]    rd_len;
    logic [`FIB_HASH_W-1:0]   rd_hash;
    logic                     rd_valid;

    fib_rx_parser i_fib_rx_parser (
        .clk               (clk),
        .rst               (rst),
        .rx_valid          (rx_valid),
        .data_spi_to_fib   (data_spi_to_fib),
        .rejected          (rejected),
        .start_send_to_pit (start_send_to_pit),
        .learn_hash        (learn_hash),
        .prefix_ready      (prefix_ready),
        .pit_out_prefix    (pit_out_prefix),
        .pit_out_metadata  (pit_out_metadata),
        .data_fib_to_pit   (data_fib_to_pit),
        .hash_key          (learn_key),
        .learn_we          (learn_we),
        .learn_len         (learn_len)
    );

    // Separate hash units so learning and lookup never compete
    fib_hash i_fib_hash_learn (
        .clk  (clk),
        .rst  (rst),
        .key  (learn_key),
        .hash (learn_hash)
    );

    fib_hash i_fib_hash_lookup (
        .clk  (clk),
        .rst  (rst),
        .key  (lookup_key),
        .hash (lookup_hash)
    );

    fib_valid_table i_fib_valid_table (
        .clk        (clk),
        .rst        (rst),
        .learn_we   (learn_we),
        .learn_len  (learn_len),
        .learn_hash (learn_hash),
        .rd_len     (rd_len),
        .rd_hash    (rd_hash),
        .rd_valid   (rd_valid)
    );

    fib_lpm_engine i_fib_lpm_engine (
        .clk             (clk),
        .rst             (rst),
        .lookup_start    (lookup_start),
        .pit_in_prefix   (pit_in_prefix),
        .pit_in_metadata (pit_in_metadata),
        .lookup_hash     (lookup_hash),
        .rd_valid        (rd_valid),
        .hash_key        (lookup_key),
        .rd_len          (rd_len),
        .rd_hash         (rd_hash),
        .spi_tx_valid    (spi_tx_valid),
        .data_fib_to_spi (data_fib_to_spi)
    );

endmodule

/* fib_valid_table.sv */
`timescale 1ns/1ps
`include "fib_settings.svh"

module fib_valid_table (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   learn_we,
    input  logic [`FIB_LEN_W-1:0]  learn_len,
    input  logic [`FIB_HASH_W-1:0] learn_hash,
    input  logic [`FIB_LEN_W-1:0]  rd_len,
    input  logic [`FIB_HASH_W-1:0] rd_hash,
    output logic                   rd_valid
);

    // Entries per length row
    localparam int ROW_BITS = 1 << `FIB_HASH_W;

    // One row of valid bits per prefix length
    logic [ROW_BITS-1:0] rows [`FIB_LENGTHS];

    // Bits are only ever set, reset is the only way to forget a prefix
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `FIB_LENGTHS; i++) begin
                rows[i] <= '0;
            end
        end else if (learn_we) begin
            rows[learn_len][learn_hash] <= 1'b1;
        end
    end

    // Combinational read, a write shows up the cycle after it
    assign rd_valid = rows[rd_len][rd_hash];

endmodule

/* files.f */
+incdir+.
fib_pkg.sv
fib_hash.sv
fib_valid_table.sv
fib_rx_parser.sv
fib_lpm_engine.sv
fib_table.sv
tb_fib_table.sv

/* run.sh */
#!/bin/sh
# Build the FIB testbench with Verilator and run it
# A run fails when its log holds the fail message

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_fib_table -f files.f -o tb_fib_table \
    && ./obj_dir/tb_fib_table | tee sim.log \
    || { echo "build or run error"; exit 1; }

grep -q "FAIL: see errors above" sim.log && { echo "simulation failed"; exit 1; }
grep -q "PASS: all tests" sim.log || { echo "simulation did not finish"; exit 1; }
echo "simulation passed"

/* tb_fib_model.svh */
`ifndef TB_FIB_MODEL_SVH
`define TB_FIB_MODEL_SVH

// Shadow copy of the valid bits, one row per prefix length
bit shadow_valid [`FIB_LENGTHS][1 << `FIB_HASH_W];

// Table index: six 10-bit slices of the prefix and the top nibble, all XORed
function automatic logic [`FIB_HASH_W-1:0] index_of(input logic [`FIB_PREFIX_W-1:0] key);
    logic [`FIB_HASH_W-1:0] h;
    h = key[9:0] ^ key[19:10] ^ key[29:20] ^ key[39:30] ^ key[49:40] ^ key[59:50];
    h = h ^ {6'd0, key[63:60]};
    return h;
endfunction

// Mirror of a finished learning write
function automatic void record_learn(input logic [`FIB_BYTE_W-1:0] meta,
                                     input logic [`FIB_PREFIX_W-1:0] prefix);
    shadow_valid[meta[`FIB_LEN_W-1:0]][index_of(prefix)] = 1'b1;
endfunction

// Walk down from the requested length, clearing bit L on each miss
function automatic logic [`FIB_PREFIX_W-1:0] expected_match(
    input logic [`FIB_BYTE_W-1:0] meta, input logic [`FIB_PREFIX_W-1:0] prefix,
    output int hit_len);
    logic [`FIB_PREFIX_W-1:0] work;
    int len;
    work = prefix;
    len = int'(meta[`FIB_LEN_W-1:0]);
    while (len > 0 && !shadow_valid[len][index_of(work)]) begin
        work[len] = 1'b0;
        len--;
    end
    hit_len = len;
    return work;
endfunction

`endif

/* tb_fib_table.sv */
`timescale 1ns/1ps
`include "fib_settings.svh"

module tb_fib_table;

    // Cycle budgets summed by the watchdog
    localparam int TX_BYTES = 1 + 2 * `FIB_PREFIX_BYTES;
    localparam int SEARCH_MAX = 2 * `FIB_LENGTHS + 8;
    localparam int LOOKUP_CYCLES = SEARCH_MAX + TX_BYTES + 4;
    localparam int PACKET_CYCLES = 16 + `FIB_PREFIX_BYTES + 2 * `FIB_DATA_BYTES;
    localparam int WATCHDOG_CYCLES = 20 + 3 * PACKET_CYCLES + 3 * LOOKUP_CYCLES + 100;
    localparam int PAYLOAD_W = `FIB_DATA_BYTES * `FIB_BYTE_W;

    logic                     clk;
    logic                     rst;
    logic                     rx_valid;
    logic [`FIB_BYTE_W-1:0]   data_spi_to_fib;
    logic                     rejected;
    logic                     start_send_to_pit;
    logic                     lookup_start;
    logic [`FIB_PREFIX_W-1:0] pit_in_prefix;
    logic [`FIB_BYTE_W-1:0]   pit_in_metadata;
    logic                     prefix_ready;
    logic [`FIB_PREFIX_W-1:0] pit_out_prefix;
    logic [`FIB_BYTE_W-1:0]   pit_out_metadata;
    logic [`FIB_BYTE_W-1:0]   data_fib_to_pit;
    logic                     spi_tx_valid;
    logic [`FIB_BYTE_W-1:0]   data_fib_to_spi;

    int errors = 0;
    int tests_run = 0;
    int tests_failed = 0;

    `include "tb_fib_model.svh"

    fib_table i_fib_table (
        .clk               (clk),
        .rst               (rst),
        .rx_valid          (rx_valid),
        .data_spi_to_fib   (data_spi_to_fib),
        .rejected          (rejected),
        .start_send_to_pit (start_send_to_pit),
        .lookup_start      (lookup_start),
        .pit_in_prefix     (pit_in_prefix),
        .pit_in_metadata   (pit_in_metadata),
        .prefix_ready      (prefix_ready),
        .pit_out_prefix    (pit_out_prefix),
        .pit_out_metadata  (pit_out_metadata),
        .data_fib_to_pit   (data_fib_to_pit),
        .spi_tx_valid      (spi_tx_valid),
        .data_fib_to_spi   (data_fib_to_spi)
    );

    // 100 MHz
    always #5 clk = ~clk;

    task automatic report_value(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
        $display("FAIL %s: got %0h expected %0h", name, got, exp);
        errors++;
    endtask

    task automatic report_error(input string what);
        $display("Error: %s", what);
        errors++;
    endtask

    // PIT strobe never lasts two cycles
    assert property (@(posedge clk) disable iff (rst) !(prefix_ready && $past(prefix_ready)))
        else report_error("prefix_ready stayed high for two cycles");

    function automatic logic [`FIB_BYTE_W-1:0] make_meta(input bit interest, input int len);
        logic [`FIB_BYTE_W-1:0] m;
        m = 8'(len) & 8'h3f;
        m[`FIB_INTEREST_BIT] = interest;
        return m;
    endfunction

    // Start pulse and metadata and then the prefix MSB first
    task automatic send_header(input logic [7:0] meta, input logic [63:0] prefix);
        @(posedge clk);
        rx_valid <= 1'b1;
        @(posedge clk);
        rx_valid        <= 1'b0;
        data_spi_to_fib <= meta;
        for (int i = 0; i < `FIB_PREFIX_BYTES; i++) begin
            @(posedge clk);
            data_spi_to_fib <= prefix[`FIB_PREFIX_W-1-8*i -: `FIB_BYTE_W];
        end
    endtask

    task automatic send_payload(input logic [PAYLOAD_W-1:0] payload);
        for (int k = 0; k < `FIB_DATA_BYTES; k++) begin
            @(posedge clk);
            data_spi_to_fib <= payload[PAYLOAD_W-1-8*k -: `FIB_BYTE_W];
        end
    endtask

    // Exactly one pulse one cycle after the last byte
    task automatic check_handoff(input logic [7:0] meta, input logic [63:0] prefix);
        @(negedge clk);
        assert (!prefix_ready) else report_error("prefix_ready came before the last byte");
        @(negedge clk);
        assert (prefix_ready) else report_error("no prefix_ready after the last byte");
        assert (pit_out_prefix == prefix)
            else report_value("pit_out_prefix", pit_out_prefix, prefix);
        assert (pit_out_metadata == meta)
            else report_value("pit_out_metadata", pit_out_metadata, meta);
        @(negedge clk);
        assert (!prefix_ready) else report_error("second prefix_ready pulse");
    endtask

    // PIT takes the packet after a short delay and bytes follow at a fixed cadence
    task automatic accept_payload(input logic [PAYLOAD_W-1:0] payload);
        repeat (3) @(posedge clk);
        start_send_to_pit <= 1'b1;
        @(posedge clk);
        start_send_to_pit <= 1'b0;
        @(posedge clk);
        for (int k = 0; k < `FIB_DATA_BYTES; k++) begin
            @(negedge clk);
            assert (data_fib_to_pit == payload[PAYLOAD_W-1-8*k -: `FIB_BYTE_W])
                else report_value($sformatf("data_fib_to_pit byte %0d", k), data_fib_to_pit,
                                  payload[PAYLOAD_W-1-8*k -: `FIB_BYTE_W]);
        end
        // Hash and learning write
        repeat (3) @(posedge clk);
    endtask

    task automatic reject_packet();
        repeat (2) @(posedge clk);
        rejected <= 1'b1;
        @(posedge clk);
        rejected <= 1'b0;
        repeat (3) @(posedge clk);
    endtask

    task automatic run_lookup(input logic [7:0] meta, input logic [63:0] prefix,
                              output int hit_len);
        logic [`FIB_PREFIX_W-1:0] match;
        logic [`FIB_BYTE_W-1:0] exp_bytes [TX_BYTES];
        int waited;
        match = expected_match(meta, prefix, hit_len);
        exp_bytes[0] = meta;
        for (int i = 0; i < `FIB_PREFIX_BYTES; i++) begin
            exp_bytes[1 + i] = prefix[`FIB_PREFIX_W-1-8*i -: `FIB_BYTE_W];
            exp_bytes[1 + `FIB_PREFIX_BYTES + i] = match[`FIB_PREFIX_W-1-8*i -: `FIB_BYTE_W];
        end
        @(posedge clk);
        lookup_start    <= 1'b1;
        pit_in_prefix   <= prefix;
        pit_in_metadata <= meta;
        @(posedge clk);
        lookup_start <= 1'b0;
        waited = 0;
        @(negedge clk);
        // Search time depends on how far the length walks down
        while (!spi_tx_valid && waited < SEARCH_MAX) begin
            @(negedge clk);
            waited++;
        end
        assert (spi_tx_valid) else report_error("lookup never raised spi_tx_valid");
        if (spi_tx_valid) begin
            for (int i = 0; i < TX_BYTES; i++) begin
                assert (spi_tx_valid)
                    else report_error($sformatf("spi_tx_valid dropped at byte %0d", i));
                assert (data_fib_to_spi == exp_bytes[i])
                    else report_value($sformatf("data_fib_to_spi byte %0d", i),
                                      data_fib_to_spi, exp_bytes[i]);
                @(negedge clk);
            end
            assert (!spi_tx_valid) else report_error("spi_tx_valid ran past the last byte");
        end
    endtask

    task automatic end_test(input string name, input int start_errors);
        tests_run++;
        if (errors > start_errors) begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - start_errors);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    initial begin
        logic [`FIB_PREFIX_W-1:0] a_prefix;
        logic [`FIB_PREFIX_W-1:0] b_prefix;
        logic [`FIB_PREFIX_W-1:0] q_prefix;
        logic [PAYLOAD_W-1:0]     payload;
        int start_errors;
        int hit_len;
        clk = 1'b0;
        rst = 1'b1;
        rx_valid = 1'b0;
        data_spi_to_fib = '0;
        rejected = 1'b0;
        start_send_to_pit = 1'b0;
        lookup_start = 1'b0;
        pit_in_prefix = '0;
        pit_in_metadata = '0;
        void'($urandom(32'h301b));
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        // Outputs quiet with no traffic
        start_errors = errors;
        repeat (10) begin
            @(negedge clk);
            assert (!prefix_ready) else report_error("prefix_ready high while idle");
            assert (!spi_tx_valid) else report_error("spi_tx_valid high while idle");
        end
        end_test("idle after reset", start_errors);

        // Empty table so the search walks all the way to length zero
        start_errors = errors;
        a_prefix = {$urandom, $urandom};
        run_lookup(make_meta(1'b1, 63), a_prefix, hit_len);
        end_test("lookup on empty table", start_errors);

        start_errors = errors;
        a_prefix = {$urandom, $urandom};
        send_header(make_meta(1'b1, 20), a_prefix);
        check_handoff(make_meta(1'b1, 20), a_prefix);
        repeat (3) @(posedge clk);
        record_learn(make_meta(1'b1, 20), a_prefix);
        end_test("interest packet", start_errors);

        start_errors = errors;
        b_prefix = {$urandom, $urandom};
        for (int i = 0; i < PAYLOAD_W / 32; i++) begin
            payload[32*i +: 32] = $urandom;
        end
        send_header(make_meta(1'b0, 33), b_prefix);
        send_payload(payload);
        check_handoff(make_meta(1'b0, 33), b_prefix);
        accept_payload(payload);
        record_learn(make_meta(1'b0, 33), b_prefix);
        end_test("data packet to PIT", start_errors);

        start_errors = errors;
        run_lookup(make_meta(1'b1, 20), a_prefix, hit_len);
        end_test("lookup exact length", start_errors);

        // Learned entry is the lookup prefix with bits 40..13 cleared at length 12
        start_errors = errors;
        b_prefix = {$urandom, $urandom};
        q_prefix = b_prefix;
        for (int i = 13; i <= 40; i++) begin
            q_prefix[i] = 1'b0;
        end
        send_header(make_meta(1'b0, 12), q_prefix);
        send_payload(payload);
        check_handoff(make_meta(1'b0, 12), q_prefix);
        reject_packet();
        record_learn(make_meta(1'b0, 12), q_prefix);
        run_lookup(make_meta(1'b1, 40), b_prefix, hit_len);
        assert (hit_len == 12) else report_error("search did not reach the shorter entry");
        end_test("lookup shorter length", start_errors);

        $display("tests: %0d run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Error: watchdog expired after %0d cycles", WATCHDOG_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule
